//--- aznable_io.f
aznable_map_pkg.sv
aznable_av_pkg.sv
cpu_bus_if.sv
io_bus_decoder.sv
input_ports.sv
ms_timer.sv
system_control.sv
av_mixer.sv
aznable_io.sv
tb_checker.sv
tb_aznable_io.sv

//--- Bender.yml
package:
  name: aznable_io

sources:
  - aznable_map_pkg.sv
  - aznable_av_pkg.sv
  - cpu_bus_if.sv
  - io_bus_decoder.sv
  - input_ports.sv
  - ms_timer.sv
  - system_control.sv
  - av_mixer.sv
  - aznable_io.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_aznable_io.sv

//--- tb_aznable_io.sv
`default_nettype none
`timescale 1ns/10ps

module tb_aznable_io;

	localparam int MS_DIVIDER = 24;
	localparam int CLK_PERIOD = 100;

	localparam logic [2:0] OP_WRITE = 3'd0;
	localparam logic [2:0] OP_READ = 3'd1;
	localparam logic [2:0] OP_PINS = 3'd2;
	localparam logic [2:0] OP_WAIT = 3'd3;
	localparam logic [2:0] OP_SWEEP = 3'd4;
	localparam logic [2:0] OP_RAND = 3'd5;

	// pins data is {hsync, vsync, hblank, vblank, 2'b0, menu, pause}
	// rand data bit 0 gives random alphas and leaves them all low when clear
	typedef struct packed
	{
		logic [2:0] op;
		logic [15:0] addr;
		logic [7:0] data;
		logic check;
		logic [7:0] expected;
	} step_t;

	localparam int STEPS = 48;

	step_t steps [STEPS] = '{
		{OP_PINS, 16'h0000, 8'h00, 1'b0, 8'h00},
		{OP_READ, 16'h8000, 8'h00, 1'b1, 8'h08},
		{OP_PINS, 16'h0000, 8'hA2, 1'b0, 8'h00},
		{OP_READ, 16'h8000, 8'h00, 1'b1, 8'hAA},
		{OP_PINS, 16'h0000, 8'h50, 1'b0, 8'h00},
		{OP_READ, 16'h8000, 8'h00, 1'b1, 8'h58},
		{OP_READ, 16'h8531, 8'h00, 1'b1, 8'hFF},
		{OP_WRITE, 16'h8531, 8'h00, 1'b0, 8'h00},
		{OP_READ, 16'h8531, 8'h00, 1'b1, 8'h00},
		{OP_RAND, 16'h0000, 8'h00, 1'b0, 8'h00},
		{OP_SWEEP, 16'h8080, 8'd32, 1'b0, 8'h00},
		{OP_SWEEP, 16'h8100, 8'd32, 1'b0, 8'h00},
		{OP_SWEEP, 16'h8200, 8'd32, 1'b0, 8'h00},
		{OP_SWEEP, 16'h8280, 8'd32, 1'b0, 8'h00},
		{OP_SWEEP, 16'h8300, 8'd32, 1'b0, 8'h00},
		{OP_SWEEP, 16'h8380, 8'd32, 1'b0, 8'h00},
		{OP_SWEEP, 16'h8400, 8'd32, 1'b0, 8'h00},
		{OP_SWEEP, 16'h8480, 8'd32, 1'b0, 8'h00},
		{OP_SWEEP, 16'h8000, 8'd32, 1'b0, 8'h00},
		{OP_READ, 16'h0000, 8'h00, 1'b1, 8'h00},
		{OP_READ, 16'h80A0, 8'h00, 1'b1, 8'h00},
		{OP_READ, 16'h8600, 8'h00, 1'b1, 8'h00},
		{OP_READ, 16'hC000, 8'h00, 1'b1, 8'h00},
		{OP_WRITE, 16'h80C0, 8'h00, 1'b0, 8'h00},
		{OP_WAIT, 16'h0000, 8'd60, 1'b0, 8'h00},
		{OP_READ, 16'h80C0, 8'h00, 1'b0, 8'h00},
		{OP_READ, 16'h80C1, 8'h00, 1'b0, 8'h00},
		{OP_WAIT, 16'h0000, 8'd200, 1'b0, 8'h00},
		{OP_READ, 16'h80C0, 8'h00, 1'b0, 8'h00},
		{OP_READ, 16'h80C1, 8'h00, 1'b0, 8'h00},
		{OP_READ, 16'h8530, 8'h00, 1'b1, 8'h00},
		{OP_WRITE, 16'h8530, 8'h00, 1'b0, 8'h00},
		{OP_WAIT, 16'h0000, 8'd5, 1'b0, 8'h00},
		{OP_PINS, 16'h0000, 8'h01, 1'b0, 8'h00},
		{OP_WAIT, 16'h0000, 8'd4, 1'b0, 8'h00},
		{OP_PINS, 16'h0000, 8'h00, 1'b0, 8'h00},
		{OP_WAIT, 16'h0000, 8'd3, 1'b0, 8'h00},
		{OP_PINS, 16'h0000, 8'h01, 1'b0, 8'h00},
		{OP_WRITE, 16'h8530, 8'h00, 1'b0, 8'h00},
		{OP_WAIT, 16'h0000, 8'd2, 1'b0, 8'h00},
		{OP_PINS, 16'h0000, 8'h00, 1'b0, 8'h00},
		{OP_WAIT, 16'h0000, 8'd3, 1'b0, 8'h00},
		{OP_WRITE, 16'h8001, 8'h01, 1'b0, 8'h00},
		{OP_RAND, 16'h0000, 8'h01, 1'b0, 8'h00},
		{OP_RAND, 16'h0000, 8'h00, 1'b0, 8'h00},
		{OP_WRITE, 16'h8001, 8'h00, 1'b0, 8'h00},
		{OP_RAND, 16'h0000, 8'h01, 1'b0, 8'h00},
		{OP_RAND, 16'h0000, 8'h00, 1'b0, 8'h00}
	};

	logic clk_24;
	logic reset;
	logic pause;
	logic menu;
	logic hsync;
	logic vsync;
	logic hblank;
	logic vblank;
	aznable_map_pkg::cpu_addr_t cpu_addr;
	aznable_map_pkg::cpu_data_t cpu_dout;
	logic cpu_wr_n;
	aznable_map_pkg::cpu_data_t cpu_din;
	logic cpu_wait_n;
	logic [aznable_map_pkg::JOYSTICK_BITS-1:0] joystick;
	logic [aznable_map_pkg::ANALOG_BITS-1:0] analog_l;
	logic [aznable_map_pkg::ANALOG_BITS-1:0] analog_r;
	logic [aznable_map_pkg::PADDLE_BITS-1:0] paddle;
	logic [aznable_map_pkg::SPINNER_BITS-1:0] spinner;
	logic [aznable_map_pkg::PS2_KEY_BITS-1:0] ps2_key;
	logic [aznable_map_pkg::PS2_MOUSE_BITS-1:0] ps2_mouse;
	logic [aznable_map_pkg::TIMESTAMP_BITS-1:0] timestamp;
	aznable_av_pkg::rgb_t spr_rgb;
	aznable_av_pkg::rgb_t char_rgb;
	aznable_av_pkg::rgb_t tile_rgb;
	logic spr_a;
	logic char_a;
	logic tile_a;
	logic [aznable_av_pkg::STAR_LAYERS-1:0] star_on;
	aznable_av_pkg::colour_t [aznable_av_pkg::STAR_LAYERS-1:0] star_lum;
	aznable_av_pkg::music_sample_t music_in;
	aznable_av_pkg::sound_sample_t sound_in;
	aznable_av_pkg::colour_t vga_r;
	aznable_av_pkg::colour_t vga_g;
	aznable_av_pkg::colour_t vga_b;
	aznable_av_pkg::audio_sample_t audio_l;
	aznable_av_pkg::audio_sample_t audio_r;
	logic exp_valid;
	logic [7:0] exp_data;
	int error_count;
	int check_count;
	int table_errors;
	logic [31:0] rng = 32'hccd743d7;

	aznable_io #(.MS_DIVIDER(MS_DIVIDER)) DUT (.*);

	tb_checker #(.MS_DIVIDER(MS_DIVIDER)) monitor (.*);

	always #(CLK_PERIOD / 2) clk_24 = ~clk_24;

	// xorshift32
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [255:0] rand_wide();
		logic [255:0] w;
		for (int i = 0; i < 8; i++)
			w[i*32 +: 32] = next_rand();
		return w;
	endfunction

	task automatic draw_inputs(input logic random_alpha);
		logic [255:0] w;
		logic [31:0] r;
		w = rand_wide();
		joystick <= w[aznable_map_pkg::JOYSTICK_BITS-1:0];
		w = rand_wide();
		analog_l <= w[aznable_map_pkg::ANALOG_BITS-1:0];
		w = rand_wide();
		analog_r <= w[aznable_map_pkg::ANALOG_BITS-1:0];
		w = rand_wide();
		paddle <= w[aznable_map_pkg::PADDLE_BITS-1:0];
		w = rand_wide();
		spinner <= w[aznable_map_pkg::SPINNER_BITS-1:0];
		w = rand_wide();
		ps2_key <= w[aznable_map_pkg::PS2_KEY_BITS-1:0];
		w = rand_wide();
		ps2_mouse <= w[aznable_map_pkg::PS2_MOUSE_BITS-1:0];
		w = rand_wide();
		timestamp <= w[aznable_map_pkg::TIMESTAMP_BITS-1:0];
		r = next_rand();
		spr_rgb <= r[23:0];
		r = next_rand();
		char_rgb <= r[23:0];
		r = next_rand();
		tile_rgb <= r[23:0];
		r = next_rand();
		star_lum <= r[23:0];
		star_on <= r[26:24];
		{tile_a, char_a, spr_a} <= random_alpha ? r[29:27] : 3'b000;
		r = next_rand();
		music_in <= r[9:0];
		sound_in <= r[27:16];
	endtask

	task automatic apply_step(input step_t s);
		int n;
		@(posedge clk_24);
		cpu_wr_n <= 1'b1;
		exp_valid <= 1'b0;
		case (s.op)
			OP_WRITE:
			begin
				cpu_addr <= s.addr;
				cpu_dout <= s.data;
				cpu_wr_n <= 1'b0;
			end
			OP_READ:
			begin
				cpu_addr <= s.addr;
				exp_valid <= s.check;
				exp_data <= s.expected;
			end
			OP_PINS:
			begin
				{hsync, vsync, hblank, vblank} <= s.data[7:4];
				menu <= s.data[1];
				pause <= s.data[0];
			end
			OP_WAIT:
				repeat (s.data) @(posedge clk_24);
			OP_SWEEP:
				for (n = 0; n < s.data; n++)
				begin
					if (n > 0)
						@(posedge clk_24);
					cpu_addr <= s.addr + 16'(n);
				end
			OP_RAND:
				for (n = 0; n < 16; n++)
				begin
					if (n > 0)
						@(posedge clk_24);
					draw_inputs(s.data[0]);
				end
			default:
			begin
				table_errors++;
				$display("unknown operation %0d in the step table", s.op);
			end
		endcase
	endtask

	initial
	begin
		clk_24 = 1'b0;
		reset = 1'b1;
		pause = 1'b0;
		menu = 1'b0;
		{hsync, vsync, hblank, vblank} = 4'b0000;
		cpu_addr = '0;
		cpu_dout = '0;
		cpu_wr_n = 1'b1;
		joystick = '0;
		analog_l = '0;
		analog_r = '0;
		paddle = '0;
		spinner = '0;
		ps2_key = '0;
		ps2_mouse = '0;
		timestamp = '0;
		spr_rgb = '0;
		char_rgb = '0;
		tile_rgb = '0;
		{spr_a, char_a, tile_a} = 3'b000;
		star_on = '0;
		star_lum = '0;
		music_in = '0;
		sound_in = '0;
		exp_valid = 1'b0;
		exp_data = '0;
		table_errors = 0;
		repeat (8) @(posedge clk_24);
		reset <= 1'b0;
		for (int i = 0; i < STEPS; i++)
			apply_step(steps[i]);
		repeat (2) @(posedge clk_24);
		$display("checks: %0d, errors: %0d", check_count, error_count + table_errors);
		if (error_count == 0 && table_errors == 0 && check_count > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// generous budget per table step
	initial
	begin
		#(STEPS * 40 * CLK_PERIOD);
		$display("timeout: the step table did not finish within %0d cycles", STEPS * 40);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_checker.sv
`default_nettype none
`timescale 1ns/10ps

module tb_checker
#(
	parameter int MS_DIVIDER = 24
)
(
	input logic clk_24,
	input logic reset,
	input logic pause,
	input logic menu,
	input logic hsync,
	input logic vsync,
	input logic hblank,
	input logic vblank,
	input logic [15:0] cpu_addr,
	input logic [7:0] cpu_dout,
	input logic cpu_wr_n,
	input logic [7:0] cpu_din,
	input logic cpu_wait_n,
	input logic [aznable_map_pkg::JOYSTICK_BITS-1:0] joystick,
	input logic [aznable_map_pkg::ANALOG_BITS-1:0] analog_l,
	input logic [aznable_map_pkg::ANALOG_BITS-1:0] analog_r,
	input logic [aznable_map_pkg::PADDLE_BITS-1:0] paddle,
	input logic [aznable_map_pkg::SPINNER_BITS-1:0] spinner,
	input logic [aznable_map_pkg::PS2_KEY_BITS-1:0] ps2_key,
	input logic [aznable_map_pkg::PS2_MOUSE_BITS-1:0] ps2_mouse,
	input logic [aznable_map_pkg::TIMESTAMP_BITS-1:0] timestamp,
	input aznable_av_pkg::rgb_t spr_rgb,
	input aznable_av_pkg::rgb_t char_rgb,
	input aznable_av_pkg::rgb_t tile_rgb,
	input logic spr_a,
	input logic char_a,
	input logic tile_a,
	input logic [2:0] star_on,
	input logic [2:0][7:0] star_lum,
	input logic [9:0] music_in,
	input logic [11:0] sound_in,
	input logic [7:0] vga_r,
	input logic [7:0] vga_g,
	input logic [7:0] vga_b,
	input logic [15:0] audio_l,
	input logic [15:0] audio_r,
	input logic exp_valid,
	input logic [7:0] exp_data,
	output int error_count,
	output int check_count
);

	// reference state of the registers behind the bus
	logic [7:0] video_q;
	logic pause_q;
	logic menu_q;
	int edges;
	aznable_av_pkg::rgb_t pixel;
	logic [15:0] audio;

	initial
	begin
		error_count = 0;
		check_count = 0;
	end

	function automatic logic between(input logic [15:0] a, input logic [15:0] lo,
		input logic [15:0] hi);
		return (a >= lo) && (a <= hi);
	endfunction

	function automatic logic [7:0] byte_of(input logic [255:0] word, input logic [15:0] offset);
		logic [255:0] shifted;
		shifted = word >> (8 * (int'(offset) % 32));
		return shifted[7:0];
	endfunction

	function automatic logic [7:0] expected_read(input logic [15:0] a);
		logic [15:0] ms;
		ms = 16'(edges / MS_DIVIDER);
		if (a == 16'h8000)
			return {hsync, vsync, hblank, vblank, 2'b10, menu, 1'b0};
		if (a == 16'h8531)
			return {8{menu_q}};
		// timer base is even so address bit 0 picks the byte
		if (between(a, 16'h80C0, 16'h80CF))
			return a[0] ? ms[15:8] : ms[7:0];
		if (between(a, 16'h8080, 16'h809F))
			return byte_of(256'(timestamp), a - 16'h8080);
		if (between(a, 16'h8100, 16'h81BF))
			return byte_of(256'(joystick), a - 16'h8100);
		if (between(a, 16'h8200, 16'h825F))
			return byte_of(256'(analog_l), a - 16'h8200);
		if (between(a, 16'h8280, 16'h82DF))
			return byte_of(256'(analog_r), a - 16'h8280);
		if (between(a, 16'h8300, 16'h832F))
			return byte_of(256'(paddle), a - 16'h8300);
		if (between(a, 16'h8380, 16'h83DF))
			return byte_of(256'(spinner), a - 16'h8380);
		if (between(a, 16'h8400, 16'h840B))
			return byte_of(256'(ps2_key), a - 16'h8400);
		if (between(a, 16'h8480, 16'h84AF))
			return byte_of(256'(ps2_mouse), a - 16'h8480);
		return 8'h00;
	endfunction

	function automatic aznable_av_pkg::rgb_t expected_pixel();
		logic [7:0] grey;
		if (star_on[0])
			grey = star_lum[0];
		else if (star_on[1])
			grey = {1'b0, star_lum[1][6:0]};
		else if (star_on[2])
			grey = {2'b00, star_lum[2][5:0]};
		else
			grey = 8'h00;
		if (video_q[0] && spr_a)
			return spr_rgb;
		if (char_a)
			return char_rgb;
		if (spr_a)
			return spr_rgb;
		if (tile_a)
			return tile_rgb;
		return {grey, grey, grey};
	endfunction

	function automatic logic [15:0] expected_audio();
		int s;
		int sum;
		s = $signed(sound_in);
		sum = int'(music_in) * 32 + ((s + 2048) & 32'hFFF) * 8 + 32'hC000;
		return sum[15:0];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERROR at %0t ns: %s expected %0h, actual %0h", $time, name, expected,
				actual);
		end
	endtask

	always @(posedge clk_24)
	begin
		if (reset)
		begin
			video_q <= 8'h00;
			pause_q <= 1'b0;
			menu_q <= 1'b0;
			edges <= 0;
		end
		else
		begin
			if (!cpu_wr_n && cpu_addr == 16'h8001)
				video_q <= cpu_dout;
			if (pause)
				pause_q <= 1'b0;
			else if (!cpu_wr_n && cpu_addr == 16'h8530)
				pause_q <= 1'b1;
			if (!cpu_wr_n && cpu_addr == 16'h8531)
				menu_q <= 1'b0;
			else if (menu)
				menu_q <= 1'b1;
			// edges since the timer was last cleared
			if (!cpu_wr_n && between(cpu_addr, 16'h80C0, 16'h80CF))
				edges <= 0;
			else
				edges <= edges + 1;
		end
	end

	// outputs settle well before the falling edge
	always @(negedge clk_24)
	begin
		if (!reset)
		begin
			pixel = expected_pixel();
			audio = expected_audio();
			compare_value("cpu_din", 32'(expected_read(cpu_addr)), 32'(cpu_din));
			compare_value("cpu_wait_n", 32'(!(pause || pause_q)), 32'(cpu_wait_n));
			compare_value("vga_r", 32'(pixel.r), 32'(vga_r));
			compare_value("vga_g", 32'(pixel.g), 32'(vga_g));
			compare_value("vga_b", 32'(pixel.b), 32'(vga_b));
			compare_value("audio_l", 32'(audio), 32'(audio_l));
			compare_value("audio_r", 32'(audio), 32'(audio_r));
			if (exp_valid)
				compare_value("cpu_din (table)", 32'(exp_data), 32'(cpu_din));
		end
	end

endmodule

`default_nettype wire

//--- aznable_io.sv
`default_nettype none
`timescale 1ns/10ps

module aznable_io
#(
	parameter int MS_DIVIDER = 24000
)
(
	input logic clk_24,
	input logic reset,
	input logic pause,
	input logic menu,
	input logic hsync,
	input logic vsync,
	input logic hblank,
	input logic vblank,

	// cpu side
	input aznable_map_pkg::cpu_addr_t cpu_addr,
	input aznable_map_pkg::cpu_data_t cpu_dout,
	input logic cpu_wr_n,
	output aznable_map_pkg::cpu_data_t cpu_din,
	output logic cpu_wait_n,

	// host inputs
	input logic [aznable_map_pkg::JOYSTICK_BITS-1:0] joystick,
	input logic [aznable_map_pkg::ANALOG_BITS-1:0] analog_l,
	input logic [aznable_map_pkg::ANALOG_BITS-1:0] analog_r,
	input logic [aznable_map_pkg::PADDLE_BITS-1:0] paddle,
	input logic [aznable_map_pkg::SPINNER_BITS-1:0] spinner,
	input logic [aznable_map_pkg::PS2_KEY_BITS-1:0] ps2_key,
	input logic [aznable_map_pkg::PS2_MOUSE_BITS-1:0] ps2_mouse,
	input logic [aznable_map_pkg::TIMESTAMP_BITS-1:0] timestamp,

	// video layers
	input aznable_av_pkg::rgb_t spr_rgb,
	input aznable_av_pkg::rgb_t char_rgb,
	input aznable_av_pkg::rgb_t tile_rgb,
	input logic spr_a,
	input logic char_a,
	input logic tile_a,
	input logic [aznable_av_pkg::STAR_LAYERS-1:0] star_on,
	input aznable_av_pkg::colour_t [aznable_av_pkg::STAR_LAYERS-1:0] star_lum,

	// audio sources
	input aznable_av_pkg::music_sample_t music_in,
	input aznable_av_pkg::sound_sample_t sound_in,

	output aznable_av_pkg::colour_t vga_r,
	output aznable_av_pkg::colour_t vga_g,
	output aznable_av_pkg::colour_t vga_b,
	output aznable_av_pkg::audio_sample_t audio_l,
	output aznable_av_pkg::audio_sample_t audio_r
);

	aznable_map_pkg::cpu_data_t input_rdata;
	aznable_map_pkg::cpu_data_t timer_rdata;
	aznable_map_pkg::cpu_data_t sysctl_rdata;
	logic sprite_above;

	cpu_bus_if bus ();

	io_bus_decoder u_decoder
	(
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.cpu_wr_n(cpu_wr_n),
		.bus(bus.decoder),
		.input_rdata(input_rdata),
		.timer_rdata(timer_rdata),
		.sysctl_rdata(sysctl_rdata),
		.cpu_din(cpu_din)
	);

	input_ports u_input_ports
	(
		.bus(bus.periph),
		.joystick(joystick),
		.analog_l(analog_l),
		.analog_r(analog_r),
		.paddle(paddle),
		.spinner(spinner),
		.ps2_key(ps2_key),
		.ps2_mouse(ps2_mouse),
		.timestamp(timestamp),
		.rdata(input_rdata)
	);

	ms_timer
	#(
		.MS_DIVIDER(MS_DIVIDER)
	)
	u_ms_timer
	(
		.clk_24(clk_24),
		.reset(reset),
		.bus(bus.periph),
		.rdata(timer_rdata)
	);

	system_control u_system_control
	(
		.clk_24(clk_24),
		.reset(reset),
		.pause(pause),
		.menu(menu),
		.hsync(hsync),
		.vsync(vsync),
		.hblank(hblank),
		.vblank(vblank),
		.bus(bus.periph),
		.rdata(sysctl_rdata),
		.sprite_above(sprite_above),
		.cpu_wait_n(cpu_wait_n)
	);

	av_mixer u_av_mixer
	(
		.sprite_above(sprite_above),
		.spr_rgb(spr_rgb),
		.char_rgb(char_rgb),
		.tile_rgb(tile_rgb),
		.spr_a(spr_a),
		.char_a(char_a),
		.tile_a(tile_a),
		.star_on(star_on),
		.star_lum(star_lum),
		.music_in(music_in),
		.sound_in(sound_in),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.audio_l(audio_l),
		.audio_r(audio_r)
	);

endmodule

`default_nettype wire

//--- av_mixer.sv
`default_nettype none
`timescale 1ns/10ps

module av_mixer
(
	input logic sprite_above,
	input aznable_av_pkg::rgb_t spr_rgb,
	input aznable_av_pkg::rgb_t char_rgb,
	input aznable_av_pkg::rgb_t tile_rgb,
	input logic spr_a,
	input logic char_a,
	input logic tile_a,
	input logic [aznable_av_pkg::STAR_LAYERS-1:0] star_on,
	input aznable_av_pkg::colour_t [aznable_av_pkg::STAR_LAYERS-1:0] star_lum,
	input aznable_av_pkg::music_sample_t music_in,
	input aznable_av_pkg::sound_sample_t sound_in,
	output aznable_av_pkg::colour_t vga_r,
	output aznable_av_pkg::colour_t vga_g,
	output aznable_av_pkg::colour_t vga_b,
	output aznable_av_pkg::audio_sample_t audio_l,
	output aznable_av_pkg::audio_sample_t audio_r
);

	aznable_av_pkg::colour_t star_grey;
	aznable_av_pkg::rgb_t star_rgb;
	aznable_av_pkg::rgb_t pixel;
	logic [11:0] sound_offset;
	aznable_av_pkg::audio_sample_t music_term;
	aznable_av_pkg::audio_sample_t sound_term;

	// walk back to front so the nearest active layer wins
	// each layer further back loses one bit of brightness
	always_comb
	begin
		star_grey = '0;
		for (int i = aznable_av_pkg::STAR_LAYERS - 1; i >= 0; i--)
		begin
			if (star_on[i])
				star_grey = star_lum[i] & (8'hFF >> i);
		end
	end

	assign star_rgb = '{r: star_grey, g: star_grey, b: star_grey};

	always_comb
	begin
		if (sprite_above)
			pixel = spr_a ? spr_rgb : char_a ? char_rgb : tile_a ? tile_rgb : star_rgb;
		else
			pixel = char_a ? char_rgb : spr_a ? spr_rgb : tile_a ? tile_rgb : star_rgb;
	end

	assign vga_r = pixel.r;
	assign vga_g = pixel.g;
	assign vga_b = pixel.b;

	// signed sound moved to offset binary before mixing
	assign sound_offset = sound_in + 12'h800;
	assign music_term = {1'b0, music_in, 5'b00000};
	assign sound_term = {1'b0, sound_offset, 3'b000};

	assign audio_l = music_term + sound_term + aznable_av_pkg::AUDIO_BIAS;
	assign audio_r = audio_l;

endmodule

`default_nettype wire

//--- system_control.sv
`default_nettype none
`timescale 1ns/10ps

module system_control
(
	input logic clk_24,
	input logic reset,
	input logic pause,
	input logic menu,
	input logic hsync,
	input logic vsync,
	input logic hblank,
	input logic vblank,
	cpu_bus_if.periph bus,
	output aznable_map_pkg::cpu_data_t rdata,
	output logic sprite_above,
	output logic cpu_wait_n
);

	aznable_map_pkg::cpu_data_t video_control;
	aznable_map_pkg::cpu_data_t status;
	logic pause_trigger;
	logic menu_trigger;

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			video_control <= '0;
			pause_trigger <= 1'b0;
			menu_trigger <= 1'b0;
		end
		else
		begin
			if (bus.wr && (bus.region == aznable_map_pkg::video_ctl))
				video_control <= bus.wdata;

			// external pause releases the trigger, even in the cycle it is written
			if (pause)
				pause_trigger <= 1'b0;
			else if (bus.wr && (bus.region == aznable_map_pkg::system_pause))
				pause_trigger <= 1'b1;

			// cpu acknowledges the menu request by writing to it
			if (bus.wr && (bus.region == aznable_map_pkg::system_menu))
				menu_trigger <= 1'b0;
			else if (menu)
				menu_trigger <= 1'b1;
		end
	end

	assign sprite_above = video_control[0];
	assign cpu_wait_n = ~(pause | pause_trigger);

	// bit 0 is the debug flag, which is never set here
	assign status = {hsync, vsync, hblank, vblank, 1'b1, 1'b0, menu, 1'b0};

	always_comb
	begin
		case (bus.region)
			aznable_map_pkg::in0: rdata = status;
			aznable_map_pkg::system_menu: rdata = {8{menu_trigger}};
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- ms_timer.sv
`default_nettype none
`timescale 1ns/10ps

module ms_timer
#(
	parameter int MS_DIVIDER = 24000
)
(
	input logic clk_24,
	input logic reset,
	cpu_bus_if.periph bus,
	output aznable_map_pkg::cpu_data_t rdata
);

	localparam int PRESCALE_BITS = $clog2(MS_DIVIDER + 1);

	logic [PRESCALE_BITS-1:0] prescaler;
	logic [15:0] count;
	logic clear;

	// any write in the timer region restarts it
	assign clear = reset || (bus.wr && (bus.region == aznable_map_pkg::timer));

	always_ff @(posedge clk_24)
	begin
		if (clear)
		begin
			prescaler <= '0;
			count <= '0;
		end
		else if (prescaler == PRESCALE_BITS'(MS_DIVIDER - 1))
		begin
			prescaler <= '0;
			count <= count + 16'd1;
		end
		else
		begin
			prescaler <= prescaler + 1'b1;
		end
	end

	// odd offsets give the high byte
	assign rdata = bus.offset[0] ? count[15:8] : count[7:0];

endmodule

`default_nettype wire

//--- input_ports.sv
`default_nettype none
`timescale 1ns/10ps

module input_ports
(
	cpu_bus_if.periph bus,
	input logic [aznable_map_pkg::JOYSTICK_BITS-1:0] joystick,
	input logic [aznable_map_pkg::ANALOG_BITS-1:0] analog_l,
	input logic [aznable_map_pkg::ANALOG_BITS-1:0] analog_r,
	input logic [aznable_map_pkg::PADDLE_BITS-1:0] paddle,
	input logic [aznable_map_pkg::SPINNER_BITS-1:0] spinner,
	input logic [aznable_map_pkg::PS2_KEY_BITS-1:0] ps2_key,
	input logic [aznable_map_pkg::PS2_MOUSE_BITS-1:0] ps2_mouse,
	input logic [aznable_map_pkg::TIMESTAMP_BITS-1:0] timestamp,
	output aznable_map_pkg::cpu_data_t rdata
);

	// one byte per offset value, so the widest word the offset can reach
	localparam int WORD_BITS = 8 * (2 ** aznable_map_pkg::IO_OFFSET_BITS);

	logic [WORD_BITS-1:0] word;

	// zero extension makes bytes past the end of a word read as zero
	always_comb
	begin
		case (bus.region)
			aznable_map_pkg::joystick: word = WORD_BITS'(joystick);
			aznable_map_pkg::analog_l: word = WORD_BITS'(analog_l);
			aznable_map_pkg::analog_r: word = WORD_BITS'(analog_r);
			aznable_map_pkg::paddle: word = WORD_BITS'(paddle);
			aznable_map_pkg::spinner: word = WORD_BITS'(spinner);
			aznable_map_pkg::ps2_key: word = WORD_BITS'(ps2_key);
			aznable_map_pkg::ps2_mouse: word = WORD_BITS'(ps2_mouse);
			aznable_map_pkg::timestamp: word = WORD_BITS'(timestamp);
			default: word = '0;
		endcase
	end

	assign rdata = word[{bus.offset, 3'b000} +: 8];

endmodule

`default_nettype wire

//--- io_bus_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module io_bus_decoder
(
	input aznable_map_pkg::cpu_addr_t cpu_addr,
	input aznable_map_pkg::cpu_data_t cpu_dout,
	input logic cpu_wr_n,
	cpu_bus_if.decoder bus,
	input aznable_map_pkg::cpu_data_t input_rdata,
	input aznable_map_pkg::cpu_data_t timer_rdata,
	input aznable_map_pkg::cpu_data_t sysctl_rdata,
	output aznable_map_pkg::cpu_data_t cpu_din
);

	aznable_map_pkg::io_region_t region;
	aznable_map_pkg::cpu_addr_t region_base;
	aznable_map_pkg::cpu_addr_t region_offset;

	function automatic logic in_range(input aznable_map_pkg::cpu_addr_t addr,
		input aznable_map_pkg::cpu_addr_t base, input aznable_map_pkg::cpu_addr_t limit);
		return (addr >= base) && (addr <= limit);
	endfunction

	// regions do not overlap so the order of the chain does not matter
	always_comb
	begin
		region = aznable_map_pkg::none;
		region_base = cpu_addr;
		if (cpu_addr == aznable_map_pkg::IN0_ADDR)
		begin
			region = aznable_map_pkg::in0;
			region_base = aznable_map_pkg::IN0_ADDR;
		end
		else if (cpu_addr == aznable_map_pkg::VIDEO_CTL_ADDR)
		begin
			region = aznable_map_pkg::video_ctl;
			region_base = aznable_map_pkg::VIDEO_CTL_ADDR;
		end
		else if (in_range(cpu_addr, aznable_map_pkg::TIMESTAMP_BASE, aznable_map_pkg::TIMESTAMP_LIMIT))
		begin
			region = aznable_map_pkg::timestamp;
			region_base = aznable_map_pkg::TIMESTAMP_BASE;
		end
		else if (in_range(cpu_addr, aznable_map_pkg::TIMER_BASE, aznable_map_pkg::TIMER_LIMIT))
		begin
			region = aznable_map_pkg::timer;
			region_base = aznable_map_pkg::TIMER_BASE;
		end
		else if (in_range(cpu_addr, aznable_map_pkg::JOYSTICK_BASE, aznable_map_pkg::JOYSTICK_LIMIT))
		begin
			region = aznable_map_pkg::joystick;
			region_base = aznable_map_pkg::JOYSTICK_BASE;
		end
		else if (in_range(cpu_addr, aznable_map_pkg::ANALOG_L_BASE, aznable_map_pkg::ANALOG_L_LIMIT))
		begin
			region = aznable_map_pkg::analog_l;
			region_base = aznable_map_pkg::ANALOG_L_BASE;
		end
		else if (in_range(cpu_addr, aznable_map_pkg::ANALOG_R_BASE, aznable_map_pkg::ANALOG_R_LIMIT))
		begin
			region = aznable_map_pkg::analog_r;
			region_base = aznable_map_pkg::ANALOG_R_BASE;
		end
		else if (in_range(cpu_addr, aznable_map_pkg::PADDLE_BASE, aznable_map_pkg::PADDLE_LIMIT))
		begin
			region = aznable_map_pkg::paddle;
			region_base = aznable_map_pkg::PADDLE_BASE;
		end
		else if (in_range(cpu_addr, aznable_map_pkg::SPINNER_BASE, aznable_map_pkg::SPINNER_LIMIT))
		begin
			region = aznable_map_pkg::spinner;
			region_base = aznable_map_pkg::SPINNER_BASE;
		end
		else if (in_range(cpu_addr, aznable_map_pkg::PS2_KEY_BASE, aznable_map_pkg::PS2_KEY_LIMIT))
		begin
			region = aznable_map_pkg::ps2_key;
			region_base = aznable_map_pkg::PS2_KEY_BASE;
		end
		else if (in_range(cpu_addr, aznable_map_pkg::PS2_MOUSE_BASE,
			aznable_map_pkg::PS2_MOUSE_LIMIT))
		begin
			region = aznable_map_pkg::ps2_mouse;
			region_base = aznable_map_pkg::PS2_MOUSE_BASE;
		end
		else if (cpu_addr == aznable_map_pkg::SYSTEM_PAUSE_ADDR)
		begin
			region = aznable_map_pkg::system_pause;
			region_base = aznable_map_pkg::SYSTEM_PAUSE_ADDR;
		end
		else if (cpu_addr == aznable_map_pkg::SYSTEM_MENU_ADDR)
		begin
			region = aznable_map_pkg::system_menu;
			region_base = aznable_map_pkg::SYSTEM_MENU_ADDR;
		end
	end

	// offset is taken from the full difference, so large regions wrap every 32 bytes
	assign region_offset = cpu_addr - region_base;

	assign bus.region = region;
	assign bus.offset = region_offset[aznable_map_pkg::IO_OFFSET_BITS-1:0];
	assign bus.wdata = cpu_dout;
	assign bus.wr = ~cpu_wr_n;

	// read data from whichever block owns the region
	always_comb
	begin
		case (region)
			aznable_map_pkg::in0,
			aznable_map_pkg::video_ctl,
			aznable_map_pkg::system_pause,
			aznable_map_pkg::system_menu: cpu_din = sysctl_rdata;
			aznable_map_pkg::timer: cpu_din = timer_rdata;
			aznable_map_pkg::timestamp,
			aznable_map_pkg::joystick,
			aznable_map_pkg::analog_l,
			aznable_map_pkg::analog_r,
			aznable_map_pkg::paddle,
			aznable_map_pkg::spinner,
			aznable_map_pkg::ps2_key,
			aznable_map_pkg::ps2_mouse: cpu_din = input_rdata;
			default: cpu_din = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- cpu_bus_if.sv
`default_nettype none
`timescale 1ns/10ps

interface cpu_bus_if;

	aznable_map_pkg::io_region_t region;
	logic [aznable_map_pkg::IO_OFFSET_BITS-1:0] offset;
	aznable_map_pkg::cpu_data_t wdata;
	logic wr;

	modport decoder
	(
		output region, offset, wdata, wr
	);

	modport periph
	(
		input region, offset, wdata, wr
	);

endinterface

`default_nettype wire

//--- aznable_av_pkg.sv
`default_nettype none

package aznable_av_pkg;

	typedef logic [7:0] colour_t;

	typedef struct packed
	{
		colour_t r;
		colour_t g;
		colour_t b;
	} rgb_t;

	// starfield layers, lower index sits in front
	localparam int STAR_LAYERS = 3;

	typedef logic [9:0] music_sample_t;
	typedef logic signed [11:0] sound_sample_t;
	typedef logic [15:0] audio_sample_t;

	// dc offset added to the mixed output
	localparam audio_sample_t AUDIO_BIAS = 16'hC000;

endpackage

`default_nettype wire

//--- aznable_map_pkg.sv
`default_nettype none

package aznable_map_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;

	// one value per decoded i/o region, none covers everything unmapped
	typedef enum logic [3:0]
	{
		none,
		in0,
		video_ctl,
		timestamp,
		timer,
		joystick,
		analog_l,
		analog_r,
		paddle,
		spinner,
		ps2_key,
		ps2_mouse,
		system_pause,
		system_menu
	} io_region_t;

	// single address registers
	localparam cpu_addr_t IN0_ADDR = 16'h8000;
	localparam cpu_addr_t VIDEO_CTL_ADDR = 16'h8001;
	localparam cpu_addr_t SYSTEM_PAUSE_ADDR = 16'h8530;
	localparam cpu_addr_t SYSTEM_MENU_ADDR = 16'h8531;

	// ranged regions, limit is the last address inside the region
	localparam cpu_addr_t TIMESTAMP_BASE = 16'h8080;
	localparam cpu_addr_t TIMESTAMP_LIMIT = 16'h809F;
	localparam cpu_addr_t TIMER_BASE = 16'h80C0;
	localparam cpu_addr_t TIMER_LIMIT = 16'h80CF;
	localparam cpu_addr_t JOYSTICK_BASE = 16'h8100;
	localparam cpu_addr_t JOYSTICK_LIMIT = 16'h81BF;
	localparam cpu_addr_t ANALOG_L_BASE = 16'h8200;
	localparam cpu_addr_t ANALOG_L_LIMIT = 16'h825F;
	localparam cpu_addr_t ANALOG_R_BASE = 16'h8280;
	localparam cpu_addr_t ANALOG_R_LIMIT = 16'h82DF;
	localparam cpu_addr_t PADDLE_BASE = 16'h8300;
	localparam cpu_addr_t PADDLE_LIMIT = 16'h832F;
	localparam cpu_addr_t SPINNER_BASE = 16'h8380;
	localparam cpu_addr_t SPINNER_LIMIT = 16'h83DF;
	localparam cpu_addr_t PS2_KEY_BASE = 16'h8400;
	localparam cpu_addr_t PS2_KEY_LIMIT = 16'h840B;
	localparam cpu_addr_t PS2_MOUSE_BASE = 16'h8480;
	localparam cpu_addr_t PS2_MOUSE_LIMIT = 16'h84AF;

	localparam int IO_OFFSET_BITS = 5;

	// host input word widths
	localparam int JOYSTICK_BITS = 192;
	localparam int ANALOG_BITS = 96;
	localparam int PADDLE_BITS = 48;
	localparam int SPINNER_BITS = 96;
	localparam int PS2_KEY_BITS = 11;
	localparam int PS2_MOUSE_BITS = 48;
	localparam int TIMESTAMP_BITS = 33;

endpackage

`default_nettype wire
